// File: include/sb_params.svh
// Sizing defines for the scoreboard slice: entries, id width, data width, multiplier latency
`ifndef SB_PARAMS_SVH
`define SB_PARAMS_SVH

// Number of scoreboard entries, power of two
`define SB_ENTRIES 8

// Transaction id width, log2 of the entry count
`define SB_ID_W 3

// Operand and result width
`define SB_DATA_W 32

// Cycles from multiplier dispatch to its writeback
`define SB_MUL_LAT 4

`endif

// File: hdl/sb_pkg.sv
// Shared types: opcode, exception and state enums, instruction, entry and bus structs
`default_nettype none

`include "sb_params.svh"

package sb_pkg;

  // Operations understood by the execution unit
  typedef enum logic [2:0] {
    ADD     = 3'd0,
    SUB     = 3'd1,
    AND     = 3'd2,
    XOR     = 3'd3,
    MUL     = 3'd4,
    ILLEGAL = 3'd5
  } opcode_e;

  // Exception causes carried with a result
  typedef enum logic [1:0] {
    NONE       = 2'd0,
    ILLEGAL_OP = 2'd1,
    OVERFLOW   = 2'd2
  } exc_cause_e;

  // Commit controller states
  typedef enum logic {
    RUN   = 1'b0,
    FLUSH = 1'b1
  } commit_state_e;

  // Decoded instruction from the front end
  typedef struct packed {
    opcode_e               opcode;
    logic [4:0]            rd;
    logic [`SB_DATA_W-1:0] op_a;
    logic [`SB_DATA_W-1:0] op_b;
  } instr_t;

  // One row of the scoreboard table
  typedef struct packed {
    logic                  issued;  // entry occupied
    logic                  done;    // result written back
    instr_t                instr;
    logic [`SB_DATA_W-1:0] result;
    exc_cause_e            cause;
  } sb_entry_t;

  // Scoreboard to execution unit
  typedef struct packed {
    opcode_e               opcode;
    logic [`SB_DATA_W-1:0] op_a;
    logic [`SB_DATA_W-1:0] op_b;
    logic [`SB_ID_W-1:0]   id;
  } dispatch_t;

  // Tagged result from one execution path
  typedef struct packed {
    logic                  valid;
    logic [`SB_ID_W-1:0]   id;
    logic [`SB_DATA_W-1:0] result;
    exc_cause_e            cause;
  } wb_t;

  // Retired instruction
  typedef struct packed {
    logic                  valid;
    logic [`SB_ID_W-1:0]   id;
    logic [4:0]            rd;
    logic [`SB_DATA_W-1:0] result;
    exc_cause_e            cause;
  } commit_t;

endpackage

`default_nettype wire

// File: hdl/mul_timer.sv
// Multiplier latency down-counter with busy flag and completion pulse
`timescale 1ns/1ps
`default_nettype none

`include "sb_params.svh"

module mul_timer (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic clear_i,
  output logic busy_o,
  output logic done_o
);

  localparam int unsigned CNT_W = $clog2(`SB_MUL_LAT + 1);

  logic [CNT_W-1:0] count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (clear_i) begin
      // Flushed multiply never reaches one
      count_q <= '0;
    end else if (start_i) begin
      count_q <= CNT_W'(`SB_MUL_LAT);
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign busy_o = (count_q != '0);
  // Last cycle of the latency window
  assign done_o = (count_q == CNT_W'(1)) && !clear_i;

endmodule

`default_nettype wire

// File: hdl/scoreboard.sv
// Scoreboard: circular entry table with issue, dispatch and commit pointers, credits and flush
`timescale 1ns/1ps
`default_nettype none

`include "sb_params.svh"

module scoreboard (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Front end, credit based
  input  logic               instr_valid_i,
  input  sb_pkg::instr_t     instr_i,
  output logic               credit_o,
  output logic               credit_reset_o,
  // Dispatch to the execution unit
  output logic               dispatch_valid_o,
  output sb_pkg::dispatch_t  dispatch_o,
  input  logic               dispatch_ready_i,
  // Writeback from the execution unit
  input  sb_pkg::wb_t        alu_wb_i,
  input  sb_pkg::wb_t        mul_wb_i,
  // Commit side
  output sb_pkg::sb_entry_t  head_o,
  input  logic               commit_ack_i,
  input  logic               flush_i
);
  import sb_pkg::*;

  // Extra wrap bit tells a full table from an empty one
  localparam int unsigned PTR_W = `SB_ID_W + 1;

  sb_entry_t [`SB_ENTRIES-1:0] mem_q, mem_n;

  logic [PTR_W-1:0]    issue_ptr_q, issue_ptr_n;
  logic [PTR_W-1:0]    disp_ptr_q, disp_ptr_n;
  logic [`SB_ID_W-1:0] commit_ptr_q, commit_ptr_n;

  logic      credit_q;
  logic      credit_reset_q;
  logic      accept;
  logic      dispatch_fire;
  sb_entry_t disp_entry;
  wb_t [1:0] wb_in;

  // ------------------------------
  // Issue and dispatch
  // ------------------------------
  // Input ignored in the credit reset cycle
  assign accept = instr_valid_i && !credit_reset_q;

  assign disp_entry = mem_q[disp_ptr_q[`SB_ID_W-1:0]];

  // Something stored but not yet sent, and no flush in progress
  assign dispatch_valid_o = (disp_ptr_q != issue_ptr_q) && !flush_i;
  assign dispatch_fire    = dispatch_valid_o && dispatch_ready_i;

  always_comb begin
    dispatch_o.opcode = disp_entry.instr.opcode;
    dispatch_o.op_a   = disp_entry.instr.op_a;
    dispatch_o.op_b   = disp_entry.instr.op_b;
    // Table index doubles as transaction id
    dispatch_o.id     = disp_ptr_q[`SB_ID_W-1:0];
  end

  // Both writeback ports handled by one loop
  assign wb_in = {mul_wb_i, alu_wb_i};

  // ------------------------------
  // Table update
  // ------------------------------
  always_comb begin
    mem_n = mem_q;

    // New instruction at the issue pointer
    if (accept) begin
      mem_n[issue_ptr_q[`SB_ID_W-1:0]] = '{
        issued: 1'b1,
        done:   1'b0,
        instr:  instr_i,
        result: '0,
        cause:  NONE
      };
    end

    // Results only land on entries still occupied
    for (int unsigned i = 0; i < 2; i++) begin
      if (wb_in[i].valid && mem_q[wb_in[i].id].issued) begin
        mem_n[wb_in[i].id].done   = 1'b1;
        mem_n[wb_in[i].id].result = wb_in[i].result;
        mem_n[wb_in[i].id].cause  = wb_in[i].cause;
      end
    end

    // Retire head
    if (commit_ack_i) begin
      mem_n[commit_ptr_q] = '0;
    end

    // Flush wins over everything above
    if (flush_i) begin
      mem_n = '0;
    end
  end

  // Pointer next state
  always_comb begin
    issue_ptr_n  = issue_ptr_q + PTR_W'(accept);
    disp_ptr_n   = disp_ptr_q + PTR_W'(dispatch_fire);
    commit_ptr_n = commit_ptr_q + `SB_ID_W'(commit_ack_i);
    if (flush_i) begin
      issue_ptr_n  = '0;
      disp_ptr_n   = '0;
      commit_ptr_n = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q          <= '0;
      issue_ptr_q    <= '0;
      disp_ptr_q     <= '0;
      commit_ptr_q   <= '0;
      credit_q       <= 1'b0;
      credit_reset_q <= 1'b0;
    end else begin
      mem_q          <= mem_n;
      issue_ptr_q    <= issue_ptr_n;
      disp_ptr_q     <= disp_ptr_n;
      commit_ptr_q   <= commit_ptr_n;
      // One credit per freed entry, seen once the slot is free
      credit_q       <= commit_ack_i;
      // Whole table freed, sender restarts its count
      credit_reset_q <= flush_i;
    end
  end

  // ------------------------------
  // Outputs
  // ------------------------------
  assign credit_o       = credit_q;
  assign credit_reset_o = credit_reset_q;
  assign head_o         = mem_q[commit_ptr_q];

endmodule

`default_nettype wire

// File: hdl/exec_unit.sv
// Execution unit: single-cycle ALU and multi-cycle multiplier with tagged writeback ports
`timescale 1ns/1ps
`default_nettype none

`include "sb_params.svh"

module exec_unit (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               dispatch_valid_i,
  input  sb_pkg::dispatch_t  dispatch_i,
  output logic               dispatch_ready_o,
  input  logic               flush_i,
  output sb_pkg::wb_t        alu_wb_o,
  output sb_pkg::wb_t        mul_wb_o
);
  import sb_pkg::*;

  logic                  fire;
  logic                  alu_fire;
  logic                  mul_fire;
  logic                  mul_busy;
  logic                  mul_done;
  logic [`SB_DATA_W-1:0] sum;
  logic [`SB_DATA_W-1:0] diff;
  logic [`SB_DATA_W-1:0] alu_result;
  exc_cause_e            alu_cause;
  wb_t                   alu_wb_q;
  logic [`SB_DATA_W-1:0] mul_a_q;
  logic [`SB_DATA_W-1:0] mul_b_q;
  logic [`SB_ID_W-1:0]   mul_id_q;
  logic [`SB_DATA_W-1:0] mul_result;

  // Only a second multiply waits, ALU ops pass a busy multiplier
  assign dispatch_ready_o = !(mul_busy && (dispatch_i.opcode == MUL));

  assign fire     = dispatch_valid_i && dispatch_ready_o && !flush_i;
  assign alu_fire = fire && (dispatch_i.opcode != MUL);
  assign mul_fire = fire && (dispatch_i.opcode == MUL);

  // ------------------------------
  // ALU path
  // ------------------------------
  assign sum  = dispatch_i.op_a + dispatch_i.op_b;
  assign diff = dispatch_i.op_a - dispatch_i.op_b;

  always_comb begin
    alu_result = '0;
    alu_cause  = NONE;
    case (dispatch_i.opcode)
      ADD: begin
        alu_result = sum;
        // Same operand signs, result sign flipped
        if ((dispatch_i.op_a[`SB_DATA_W-1] == dispatch_i.op_b[`SB_DATA_W-1]) &&
            (sum[`SB_DATA_W-1] != dispatch_i.op_a[`SB_DATA_W-1])) begin
          alu_cause = OVERFLOW;
        end
      end
      SUB: begin
        alu_result = diff;
        if ((dispatch_i.op_a[`SB_DATA_W-1] != dispatch_i.op_b[`SB_DATA_W-1]) &&
            (diff[`SB_DATA_W-1] != dispatch_i.op_a[`SB_DATA_W-1])) begin
          alu_cause = OVERFLOW;
        end
      end
      AND: alu_result = dispatch_i.op_a & dispatch_i.op_b;
      XOR: alu_result = dispatch_i.op_a ^ dispatch_i.op_b;
      // Undefined opcodes report as illegal with a zero result
      default: alu_cause = ILLEGAL_OP;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alu_wb_q <= '0;
    end else begin
      alu_wb_q.valid <= alu_fire;
      if (alu_fire) begin
        alu_wb_q.id     <= dispatch_i.id;
        alu_wb_q.result <= alu_result;
        alu_wb_q.cause  <= alu_cause;
      end
    end
  end

  assign alu_wb_o = alu_wb_q;

  // ------------------------------
  // Multiplier path
  // ------------------------------
  // Operands held for the whole latency
  always_ff @(posedge clk_i) begin
    if (mul_fire) begin
      mul_a_q  <= dispatch_i.op_a;
      mul_b_q  <= dispatch_i.op_b;
      mul_id_q <= dispatch_i.id;
    end
  end

  // Low half of the product
  assign mul_result = mul_a_q * mul_b_q;

  mul_timer mul_timer_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (mul_fire),
    .clear_i (flush_i),
    .busy_o  (mul_busy),
    .done_o  (mul_done)
  );

  always_comb begin
    mul_wb_o.valid  = mul_done;
    mul_wb_o.id     = mul_id_q;
    mul_wb_o.result = mul_result;
    mul_wb_o.cause  = NONE;
  end

endmodule

`default_nettype wire

// File: hdl/commit_fsm.sv
// Commit controller FSM: in-order retirement of the head entry and flush after an exception
`timescale 1ns/1ps
`default_nettype none

`include "sb_params.svh"

module commit_fsm (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  sb_pkg::sb_entry_t  head_i,
  output logic               commit_ack_o,
  output logic               flush_o,
  output sb_pkg::commit_t    commit_o
);
  import sb_pkg::*;

  commit_state_e       state_q, state_n;
  // Mirrors the scoreboard commit pointer to tag commits
  logic [`SB_ID_W-1:0] commit_id_q;
  commit_t             commit_q;

  // ------------------------------
  // Next state and ack
  // ------------------------------
  always_comb begin
    state_n      = state_q;
    commit_ack_o = 1'b0;
    case (state_q)
      RUN: begin
        if (head_i.done) begin
          commit_ack_o = 1'b1;
          // Faulting entry retires, everything younger goes
          if (head_i.cause != NONE) begin
            state_n = FLUSH;
          end
        end
      end
      FLUSH:   state_n = RUN;
      default: state_n = RUN;
    endcase
  end

  // Single flush cycle
  assign flush_o = (state_q == FLUSH);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= RUN;
      commit_id_q <= '0;
      commit_q    <= '0;
    end else begin
      state_q        <= state_n;
      commit_q.valid <= commit_ack_o;
      if (flush_o) begin
        commit_id_q <= '0;
      end else if (commit_ack_o) begin
        commit_id_q <= commit_id_q + 1'b1;
      end
      if (commit_ack_o) begin
        commit_q.id     <= commit_id_q;
        commit_q.rd     <= head_i.instr.rd;
        commit_q.result <= head_i.result;
        commit_q.cause  <= head_i.cause;
      end
    end
  end

  assign commit_o = commit_q;

endmodule

`default_nettype wire

// File: hdl/issue_core_top.sv
// Top level: scoreboard, execution unit and commit controller wired together
`timescale 1ns/1ps
`default_nettype none

module issue_core_top (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             instr_valid_i,
  input  sb_pkg::instr_t   instr_i,
  output logic             credit_o,
  output logic             credit_reset_o,
  output sb_pkg::commit_t  commit_o
);
  import sb_pkg::*;

  // Scoreboard to execution unit
  logic      dispatch_valid;
  dispatch_t dispatch;
  logic      dispatch_ready;
  wb_t       alu_wb;
  wb_t       mul_wb;

  // Scoreboard to commit controller
  sb_entry_t head;
  logic      commit_ack;
  // Shared by scoreboard and execution unit
  logic      flush;

  scoreboard scoreboard_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .instr_valid_i    (instr_valid_i),
    .instr_i          (instr_i),
    .credit_o         (credit_o),
    .credit_reset_o   (credit_reset_o),
    .dispatch_valid_o (dispatch_valid),
    .dispatch_o       (dispatch),
    .dispatch_ready_i (dispatch_ready),
    .alu_wb_i         (alu_wb),
    .mul_wb_i         (mul_wb),
    .head_o           (head),
    .commit_ack_i     (commit_ack),
    .flush_i          (flush)
  );

  exec_unit exec_unit_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dispatch_valid_i (dispatch_valid),
    .dispatch_i       (dispatch),
    .dispatch_ready_o (dispatch_ready),
    .flush_i          (flush),
    .alu_wb_o         (alu_wb),
    .mul_wb_o         (mul_wb)
  );

  commit_fsm commit_fsm_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .head_i       (head),
    .commit_ack_o (commit_ack),
    .flush_o      (flush),
    .commit_o     (commit_o)
  );

endmodule

`default_nettype wire

// File: tests/issue_core_assert.sv
// Scoreboard assertions: credit exclusivity, writeback targets and ids, commit on a done head
`timescale 1ns/1ps
`default_nettype none

`include "sb_params.svh"

module issue_core_assert (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     credit_i,
  input  logic                                     credit_reset_i,
  input  sb_pkg::wb_t                              alu_wb_i,
  input  sb_pkg::wb_t                              mul_wb_i,
  input  sb_pkg::sb_entry_t [`SB_ENTRIES-1:0]      mem_i,
  input  sb_pkg::sb_entry_t                        head_i,
  input  logic                                     commit_ack_i
);
  import sb_pkg::*;

  // ------------------------------
  // Credits
  // ------------------------------
  // Single credit and table reset are exclusive
  credit_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(credit_i && credit_reset_i))
    else $error("credit pulse and credit reset high together");

  // ------------------------------
  // Writeback
  // ------------------------------
  alu_wb_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alu_wb_i.valid |-> mem_i[alu_wb_i.id].issued)
    else $error("ALU writeback to an entry that is not issued");

  mul_wb_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mul_wb_i.valid |-> mem_i[mul_wb_i.id].issued)
    else $error("MUL writeback to an entry that is not issued");

  // Both ports in one cycle always carry different ids
  wb_ids_differ: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (alu_wb_i.valid && mul_wb_i.valid) |-> (alu_wb_i.id != mul_wb_i.id))
    else $error("both writeback ports carry the same id");

  // ------------------------------
  // Commit
  // ------------------------------
  ack_on_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_ack_i |-> head_i.done)
    else $error("commit ack on a head that is not done");

endmodule

`default_nettype wire

// File: tests/tb_issue_core.sv
// Testbench with clock, reset, credit driver, stimulus table, reference model and checks
`timescale 1ns/1ps
`default_nettype none

`include "sb_params.svh"

module tb_issue_core;
  import sb_pkg::*;

  localparam int NUM_ROWS    = 24;
  localparam int CYCLE_LIMIT = NUM_ROWS * (`SB_MUL_LAT + 6) + 100;

  // One stimulus row
  typedef struct {
    string                 name;
    opcode_e               opcode;
    logic [4:0]            rd;
    logic [`SB_DATA_W-1:0] op_a;
    logic [`SB_DATA_W-1:0] op_b;
    bit                    rnd;    // operands come from the LCG
    bit                    drain;  // wait for an empty table before sending
  } stim_row_t;

  logic    clk_i;
  logic    rst_ni;
  logic    instr_valid_i;
  instr_t  instr_i;
  logic    credit_o;
  logic    credit_reset_o;
  commit_t commit_o;

  stim_row_t   rows [NUM_ROWS];
  // Expected commits in program order with their row numbers
  commit_t     exp_q [$];
  int          exp_row_q [$];
  int          credits;
  int          issue_idx;
  bit          reset_pending;
  int          discarded;
  int          error_count;
  int          cycle_count;
  logic [31:0] lcg_state;

  issue_core_top issue_core_top_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .credit_o       (credit_o),
    .credit_reset_o (credit_reset_o),
    .commit_o       (commit_o)
  );

  bind scoreboard issue_core_assert issue_core_assert_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .credit_i       (credit_o),
    .credit_reset_i (credit_reset_o),
    .alu_wb_i       (alu_wb_i),
    .mul_wb_i       (mul_wb_i),
    .mem_i          (mem_q),
    .head_i         (head_o),
    .commit_ack_i   (commit_ack_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Expected commit worked out from the opcode rules
  function automatic commit_t predict_commit(input instr_t instr, input logic [`SB_ID_W-1:0] id);
    commit_t     c;
    longint      wide;
    longint      limit;
    logic [63:0] prod;
    c       = '0;
    c.valid = 1'b1;
    c.id    = id;
    c.rd    = instr.rd;
    c.cause = NONE;
    limit   = longint'(1) <<< (`SB_DATA_W - 1);
    case (instr.opcode)
      ADD: begin
        c.result = instr.op_a + instr.op_b;
        wide     = longint'($signed(instr.op_a)) + longint'($signed(instr.op_b));
        if ((wide >= limit) || (wide < -limit)) c.cause = OVERFLOW;
      end
      SUB: begin
        c.result = instr.op_a - instr.op_b;
        wide     = longint'($signed(instr.op_a)) - longint'($signed(instr.op_b));
        if ((wide >= limit) || (wide < -limit)) c.cause = OVERFLOW;
      end
      AND: c.result = instr.op_a & instr.op_b;
      XOR: c.result = instr.op_a ^ instr.op_b;
      MUL: begin
        prod     = 64'(instr.op_a) * 64'(instr.op_b);
        c.result = prod[`SB_DATA_W-1:0];
      end
      default: begin
        c.result = '0;
        c.cause  = ILLEGAL_OP;
      end
    endcase
    return c;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "run aborted");
  endtask

  // Name, opcode, rd, operand a, operand b, random operands, drain first
  task automatic load_table();
    rows[0]  = '{"add_basic",    ADD,     5'd1,  32'd5,          32'd7,          1'b0, 1'b0};
    rows[1]  = '{"sub_basic",    SUB,     5'd2,  32'd100,        32'd58,         1'b0, 1'b0};
    rows[2]  = '{"and_basic",    AND,     5'd3,  32'hff00_ff00,  32'h0f0f_0f0f,  1'b0, 1'b0};
    rows[3]  = '{"xor_basic",    XOR,     5'd4,  32'haaaa_5555,  32'hffff_0000,  1'b0, 1'b0};
    // MUL ahead of ALU ops so results return out of order
    rows[4]  = '{"mul_first",    MUL,     5'd5,  32'h0000_1234,  32'h0000_5678,  1'b0, 1'b1};
    rows[5]  = '{"add_past_mul", ADD,     5'd6,  32'h8000_0000,  32'd1,          1'b0, 1'b0};
    rows[6]  = '{"xor_past_mul", XOR,     5'd7,  32'h1234_5678,  32'h8765_4321,  1'b0, 1'b0};
    rows[7]  = '{"mul_rand_a",   MUL,     5'd8,  32'd0,          32'd0,          1'b1, 1'b0};
    rows[8]  = '{"and_rand",     AND,     5'd9,  32'd0,          32'd0,          1'b1, 1'b0};
    rows[9]  = '{"xor_rand",     XOR,     5'd10, 32'd0,          32'd0,          1'b1, 1'b0};
    rows[10] = '{"mul_rand_b",   MUL,     5'd11, 32'd0,          32'd0,          1'b1, 1'b0};
    rows[11] = '{"sub_wrap",     SUB,     5'd12, 32'd0,          32'd1,          1'b0, 1'b0};
    // Burst continues past the table size, exception with younger instructions behind it
    rows[12] = '{"illegal_op",   ILLEGAL, 5'd13, 32'hdead_beef,  32'h0000_0001,  1'b0, 1'b0};
    rows[13] = '{"young_add",    ADD,     5'd14, 32'd1,          32'd2,          1'b0, 1'b0};
    rows[14] = '{"young_mul",    MUL,     5'd15, 32'd3,          32'd4,          1'b0, 1'b0};
    rows[15] = '{"young_xor",    XOR,     5'd16, 32'h0000_00ff,  32'h0000_0f0f,  1'b0, 1'b0};
    rows[16] = '{"add_overflow", ADD,     5'd17, 32'h7fff_ffff,  32'd1,          1'b0, 1'b1};
    rows[17] = '{"young_sub",    SUB,     5'd18, 32'd9,          32'd3,          1'b0, 1'b0};
    // Recovery after the credit reset
    rows[18] = '{"mul_recover",  MUL,     5'd19, 32'd0,          32'd0,          1'b1, 1'b1};
    rows[19] = '{"add_recover",  ADD,     5'd20, 32'd40,         32'd2,          1'b0, 1'b0};
    rows[20] = '{"sub_overflow", SUB,     5'd21, 32'h8000_0000,  32'd1,          1'b0, 1'b0};
    rows[21] = '{"and_tail",     AND,     5'd22, 32'd0,          32'd0,          1'b1, 1'b0};
    rows[22] = '{"mul_tail",     MUL,     5'd23, 32'd6,          32'd7,          1'b0, 1'b1};
    rows[23] = '{"xor_tail",     XOR,     5'd24, 32'd0,          32'd0,          1'b1, 1'b0};
  endtask

  // ------------------------------
  // Driver
  // ------------------------------
  initial begin
    instr_t instr;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    rst_ni        = 1'b0;
    credits       = `SB_ENTRIES;
    issue_idx     = 0;
    reset_pending = 1'b0;
    discarded     = 0;
    error_count   = 0;
    lcg_state     = 32'ha6b2_9887;
    load_table();
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    for (int i = 0; i < NUM_ROWS; i++) begin
      instr.opcode = rows[i].opcode;
      instr.rd     = rows[i].rd;
      instr.op_a   = rows[i].op_a;
      instr.op_b   = rows[i].op_b;
      if (rows[i].rnd) begin
        instr.op_a = next_random();
        instr.op_b = next_random();
      end
      // Hold off without a credit or until the table has drained
      while ((credits == 0) ||
             (rows[i].drain && ((exp_q.size() != 0) || reset_pending))) begin
        instr_valid_i <= 1'b0;
        @(posedge clk_i);
      end
      instr_valid_i <= 1'b1;
      instr_i       <= instr;
      credits--;
      exp_q.push_back(predict_commit(instr, `SB_ID_W'(issue_idx)));
      exp_row_q.push_back(i);
      issue_idx = (issue_idx + 1) % `SB_ENTRIES;
      @(posedge clk_i);
    end
    instr_valid_i <= 1'b0;
    // Wait until everything is retired or flushed and all credits are back
    while ((exp_q.size() != 0) || reset_pending || (credits != `SB_ENTRIES)) begin
      @(posedge clk_i);
    end
    check_value("flush_discards", 1, discarded > 0);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // ------------------------------
  // Monitor and reference model
  // ------------------------------
  initial begin
    bit      was_pending;
    commit_t exp;
    string   name;
    @(posedge rst_ni);
    forever begin
      @(negedge clk_i);
      was_pending = reset_pending;
      if (credit_o) credits++;
      if (credit_reset_o) begin
        if (!was_pending) report_failure("Credit reset seen without an exception commit");
        // Younger instructions never commit
        discarded += exp_q.size();
        exp_q.delete();
        exp_row_q.delete();
        credits       = `SB_ENTRIES;
        issue_idx     = 0;
        reset_pending = 1'b0;
      end else if (was_pending) begin
        report_failure("No credit reset in the cycle after an exception commit");
      end
      if (commit_o.valid) begin
        if (exp_q.size() == 0) report_failure("Commit seen with no instruction outstanding");
        exp  = exp_q.pop_front();
        name = rows[exp_row_q.pop_front()].name;
        check_value({name, " id"}, exp.id, commit_o.id);
        check_value({name, " rd"}, exp.rd, commit_o.rd);
        check_value({name, " result"}, exp.result, commit_o.result);
        check_value({name, " cause"}, exp.cause, commit_o.cause);
        if (exp.cause != NONE) reset_pending = 1'b1;
      end
      if (credits > `SB_ENTRIES) report_failure("More credits returned than entries exist");
      if (exp_q.size() > `SB_ENTRIES) report_failure("More instructions in flight than entries");
    end
  end

  // Run limit
  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Test failed");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
hdl/sb_pkg.sv
hdl/mul_timer.sv
hdl/scoreboard.sv
hdl/exec_unit.sv
hdl/commit_fsm.sv
hdl/issue_core_top.sv
tests/issue_core_assert.sv
tests/tb_issue_core.sv

// File: Bender.yml
package:
  name: issue_core

export_include_dirs:
  - include

sources:
  - files:
      - hdl/sb_pkg.sv
      - hdl/mul_timer.sv
      - hdl/scoreboard.sv
      - hdl/exec_unit.sv
      - hdl/commit_fsm.sv
      - hdl/issue_core_top.sv
  - target: test
    files:
      - tests/issue_core_assert.sv
      - tests/tb_issue_core.sv
